/* ascon.f */
+incdir+verilog
verilog/ascon_data_pkg.sv
verilog/ascon_ctrl_pkg.sv
verilog/ascon_round.sv
verilog/ascon_ctrl.sv
verilog/ascon_datapath.sv
verilog/ascon_top.sv
dv/ascon_props.sv
dv/ascon_tb.sv

/* dv/ascon_props.sv */
`timescale 1ns/1ps

// protocol rules of the core as seen at the ascon_top ports
module ascon_props (
    input logic                   clk,
    input logic                   reset_n,
    input logic                   i_valid_data,
    input logic                   i_ready,
    input logic                   i_ct_valid,
    input logic                   i_tag_valid,
    input ascon_ctrl_pkg::dp_op_e i_dp_op    // controller opcode inside the top
);

    ct_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        i_ct_valid |=> !i_ct_valid)
        else $error("ciphertext valid held for more than one cycle");

    tag_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        i_tag_valid |=> !i_tag_valid)
        else $error("tag valid held for more than one cycle");

    // ciphertext only right after a block was taken
    ct_after_accept: assert property (@(posedge clk) disable iff (!reset_n)
        i_ct_valid |-> $past(i_valid_data && i_ready))
        else $error("ciphertext valid without an accepted block");

    ready_low_in_rounds: assert property (@(posedge clk) disable iff (!reset_n)
        (i_dp_op == ascon_ctrl_pkg::OP_ROUND || i_dp_op == ascon_ctrl_pkg::OP_ROUND_KEYMIX)
        |-> !i_ready)
        else $error("ready for data while the permutation runs");

endmodule

bind ascon_top ascon_props ascon_props_inst (
    .clk(clk), .reset_n(reset_n), .i_valid_data(i_valid_data), .i_ready(o_ready_for_data),
    .i_ct_valid(o_ciphertext_valid), .i_tag_valid(o_tag_valid), .i_dp_op(dp_op)
);

/* dv/ascon_tb.sv */
`timescale 1ns/1ps
`include "ascon_consts.svh"

module ascon_tb;

    localparam int N_ROWS = 8;
    localparam int CLK_NS = 100;
    // one row per message with block count, last-block valid bytes and pad-only flag
    localparam int ROW_BLOCKS [N_ROWS] = '{1, 1, 1, 1, 1, 3, 4, 5};
    localparam int ROW_BYTES  [N_ROWS] = '{16, 0, 1, 7, 15, 16, 9, 15};
    localparam bit ROW_EXTRA  [N_ROWS] = '{1, 0, 0, 0, 0, 1, 0, 0};

    logic clk, reset_n, i_start, i_valid_data, i_last_block;
    logic o_ready_for_data, o_ciphertext_valid, o_tag_valid, o_done;
    logic [`ASCON_BYTES_W-1:0] i_valid_bytes;
    ascon_data_pkg::block_t i_key, i_nonce, i_data, o_ciphertext, o_tag;

    ascon_data_pkg::block_t data_blk [8];   // plaintext of the running message
    ascon_data_pkg::block_t exp_ct [8];     // model ciphertexts
    ascon_data_pkg::block_t exp_tag;
    int n_checks, n_errors;

    ascon_top ascon_top_inst (
        .clk(clk), .reset_n(reset_n), .i_start(i_start), .i_key(i_key), .i_nonce(i_nonce),
        .i_data(i_data), .i_valid_data(i_valid_data), .i_last_block(i_last_block),
        .i_valid_bytes(i_valid_bytes), .o_ready_for_data(o_ready_for_data),
        .o_ciphertext_valid(o_ciphertext_valid), .o_ciphertext(o_ciphertext),
        .o_tag_valid(o_tag_valid), .o_tag(o_tag), .o_done(o_done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    task automatic check_block(input string name, input ascon_data_pkg::block_t got,
                               input ascon_data_pkg::block_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        n_checks++;
        if (got != exp) begin
            n_errors++;
            $display("mismatch at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(input string what);
        n_errors++;
        $display("error at %0t ns: %s", $time, what);
    endtask

    function automatic ascon_data_pkg::block_t rand_block();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    function automatic ascon_data_pkg::word_t ror(input ascon_data_pkg::word_t v, input int n);
        return (v >> n) | (v << (64 - n));
    endfunction

    // reference round with chi written out per lane and x0 on top
    function automatic ascon_data_pkg::state_t ref_round(input ascon_data_pkg::state_t s,
                                                         input int r);
        ascon_data_pkg::word_t x0, x1, x2, x3, x4, t0, t1, t2, t3, t4;
        {x0, x1, x2, x3, x4} = s;
        x2 = x2 ^ ascon_data_pkg::word_t'((15 - r) * 16 + r);   // round constant
        x0 = x0 ^ x4;
        x4 = x4 ^ x3;
        x2 = x2 ^ x1;
        t0 = x0 ^ (~x1 & x2);
        t1 = x1 ^ (~x2 & x3);
        t2 = x2 ^ (~x3 & x4);
        t3 = x3 ^ (~x4 & x0);
        t4 = x4 ^ (~x0 & x1);
        x0 = t0 ^ t4;
        x1 = t1 ^ t0;
        x2 = ~t2;
        x3 = t3 ^ t2;
        return {x0 ^ ror(x0, 19) ^ ror(x0, 28), x1 ^ ror(x1, 61) ^ ror(x1, 39),
                x2 ^ ror(x2, 1) ^ ror(x2, 6), x3 ^ ror(x3, 10) ^ ror(x3, 17),
                t4 ^ ror(t4, 7) ^ ror(t4, 41)};
    endfunction

    // pa starts at constant 0 and pb at 4
    function automatic ascon_data_pkg::state_t permute(input ascon_data_pkg::state_t s,
                                                       input int first);
        for (int r = first; r < 12; r++) begin
            s = ref_round(s, r);
        end
        return s;
    endfunction

    // expected ciphertexts and tag of one message with empty ad
    task automatic model_encrypt(input ascon_data_pkg::block_t key,
                                 input ascon_data_pkg::block_t nonce,
                                 input int nblk, input int vb);
        ascon_data_pkg::state_t s;
        ascon_data_pkg::block_t blk, ones;
        ones = '1;
        s = permute({64'h80800c0800000000, key, nonce}, 0);
        s[127:0] = s[127:0] ^ key;
        s[0]     = s[0] ^ 1'b1;   // domain bit
        for (int b = 0; b < nblk; b++) begin
            blk = data_blk[b];
            if (b == nblk - 1 && vb < 16) begin   // keep vb bytes and put the marker after them
                blk = (blk & ~(ones >> (8 * vb)))
                      | (ascon_data_pkg::block_t'(8'h80) << (8 * (15 - vb)));
            end
            s[319:192] = s[319:192] ^ blk;
            exp_ct[b]  = s[319:192];
            if (b < nblk - 1 || vb == 16) s = permute(s, 4);
            if (b == nblk - 1 && vb == 16) s[319:192] = s[319:192] ^ {8'h80, 120'h0};
        end
        s[191:64] = s[191:64] ^ key;
        s = permute(s, 0);
        exp_tag = s[127:0] ^ key;
    endtask

    task automatic run_message(input int row);
        ascon_data_pkg::block_t key, nonce;
        int nblk, vb, k, errs_before;
        bit stalled;
        nblk        = ROW_BLOCKS[row];
        vb          = ROW_BYTES[row];
        errs_before = n_errors;
        stalled     = 1'b0;
        key         = rand_block();   // fresh key and nonce every message
        nonce       = rand_block();
        for (int b = 0; b < nblk; b++) begin
            data_blk[b] = rand_block();
        end
        model_encrypt(key, nonce, nblk, vb);
        i_start = 1'b1;
        i_key   = key;
        i_nonce = nonce;
        @(negedge clk);
        i_start = 1'b0;
        k = 0;
        for (int b = 0; b < nblk && !stalled; b++) begin
            while (!o_ready_for_data && k < 40) begin
                @(negedge clk);
                k++;
            end
            if (!o_ready_for_data) begin
                report_failure("o_ready_for_data stayed low, no block could be sent");
                stalled = 1'b1;
            end else begin
                if (b > 0) check_count("ready return cycles", k, 9);   // ct_out plus pb
                i_valid_data  = 1'b1;
                i_data        = data_blk[b];
                i_last_block  = (b == nblk - 1);
                i_valid_bytes = `ASCON_BYTES_W'((b == nblk - 1) ? vb : 16);
                @(negedge clk);   // accepted on the edge in between
                i_valid_data = 1'b0;
                check_level("o_ciphertext_valid", o_ciphertext_valid, 1'b1);
                check_block("o_ciphertext", o_ciphertext, exp_ct[b]);
                @(negedge clk);
                check_level("o_ciphertext_valid", o_ciphertext_valid, 1'b0);
                k = 1;   // clock edges since the accepting one
            end
        end
        if (!stalled) begin
            while (!o_tag_valid && k < 40) begin
                @(negedge clk);
                k++;
            end
            if (!o_tag_valid) begin
                report_failure("o_tag_valid never came after the last block");
            end else begin
                // ct_out plus pb and pad-only block when full plus 12 final rounds
                check_count("tag latency", k, 1 + (ROW_EXTRA[row] ? 9 : 0) + 12);
                check_level("o_done", o_done, 1'b1);
                check_block("o_tag", o_tag, exp_tag);
                @(negedge clk);
                check_level("o_tag_valid", o_tag_valid, 1'b0);
                check_level("o_done", o_done, 1'b0);
            end
        end
        $display("test %0d: %0d blocks, last %0d bytes, %0d errors",
                 row, nblk, vb, n_errors - errs_before);
    endtask

    initial begin : watchdog
        int total;
        total = 0;
        for (int r = 0; r < N_ROWS; r++) begin
            total += ROW_BLOCKS[r];
        end
        #((total * 20 + N_ROWS * 40 + 10) * CLK_NS);
        $display("error: run did not finish in time, the DUT seems stuck");
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin : main
        void'($urandom(83));
        n_checks      = 0;
        n_errors      = 0;
        reset_n       = 1'b0;
        i_start       = 1'b0;
        i_key         = '0;
        i_nonce       = '0;
        i_data        = '0;
        i_valid_data  = 1'b0;
        i_last_block  = 1'b0;
        i_valid_bytes = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);
        check_level("o_ready_for_data", o_ready_for_data, 1'b0);   // quiet after reset
        check_level("o_ciphertext_valid", o_ciphertext_valid, 1'b0);
        check_level("o_tag_valid", o_tag_valid, 1'b0);
        check_level("o_done", o_done, 1'b0);
        for (int r = 0; r < N_ROWS; r++) begin
            run_message(r);
        end
        $display("%0d tests, %0d checks, %0d errors", N_ROWS, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* run_ascon.sh */
#!/bin/sh
# build the ascon testbench with verilator, run it, judge the log
LOG=sim.log
rm -f "$LOG"
verilator --binary --assert -f ascon.f --top-module ascon_tb -Mdir obj_dir -o ascon_sim \
    || { echo "build failed"; exit 1; }
./obj_dir/ascon_sim > "$LOG" 2>&1 || echo "simulation exited with an error status" >> "$LOG"
cat "$LOG"
grep -q "FAIL: see errors above" "$LOG" && { echo "result: failed"; exit 1; }
grep -q "PASS: all tests" "$LOG" && echo "result: passed" || { echo "result: failed"; exit 1; }

/* verilog/ascon_consts.svh */
`ifndef ASCON_CONSTS_SVH
`define ASCON_CONSTS_SVH

// state geometry
`define ASCON_WORD_W   64    // one lane of the state
`define ASCON_BLOCK_W  128   // rate of ascon-128a, two lanes
`define ASCON_STATE_W  320   // five lanes x0..x4

// permutation lengths
`define ASCON_PA_ROUNDS 12   // init and finalisation
`define ASCON_PB_ROUNDS 8    // between data blocks

// ascon-128a iv for k=128, r=128, a=12, b=8
`define ASCON_IV 64'h80800c0800000000

// padding marker right after the last valid byte
`define ASCON_PAD_BYTE 8'h80
`define ASCON_BYTES_W  5     // holds 0..16

`endif

/* verilog/ascon_ctrl.sv */
`timescale 1ns/1ps
`include "ascon_consts.svh"

module ascon_ctrl (
    input  logic                              clk,
    input  logic                              reset_n,
    input  logic                              i_start,
    input  logic                              i_valid_data,
    input  logic                              i_last_block,
    input  logic [`ASCON_BYTES_W-1:0]         i_valid_bytes,
    output ascon_ctrl_pkg::dp_op_e            o_dp_op,
    output ascon_data_pkg::round_idx_t        o_round_idx,
    output logic                              o_ready_for_data,
    output logic                              o_ciphertext_valid,
    output logic                              o_tag_valid,
    output logic                              o_done
);

    localparam ascon_data_pkg::round_idx_t LAST_RND = 4'(`ASCON_PA_ROUNDS - 1);
    // pb uses the last 8 constants of pa
    localparam ascon_data_pkg::round_idx_t PB_FIRST = 4'(`ASCON_PA_ROUNDS - `ASCON_PB_ROUNDS);

    ascon_ctrl_pkg::ctrl_state_e state, state_nx;
    ascon_ctrl_pkg::dp_op_e      op;
    ascon_data_pkg::round_idx_t  round_cnt;
    logic last_q, full_q;   // kind of the block just taken
    logic ready_q, ct_pulse_q, tag_pulse_q;
    logic accept, full_last, last_round, round_op;

    assign full_last  = (i_valid_bytes == `ASCON_BYTES_W'(`ASCON_BLOCK_W / 8));
    assign accept     = i_valid_data & ready_q;
    assign last_round = (round_cnt == LAST_RND);
    assign round_op   = (op == ascon_ctrl_pkg::OP_ROUND) || (op == ascon_ctrl_pkg::OP_ROUND_KEYMIX);

    // mealy part: opcode depends on state and inputs
    always_comb begin
        state_nx = state;
        op       = ascon_ctrl_pkg::OP_HOLD;
        case (state)
            ascon_ctrl_pkg::IDLE: if (i_start) begin
                op       = ascon_ctrl_pkg::OP_LOAD;   // iv, key, nonce into state
                state_nx = ascon_ctrl_pkg::INIT;
            end
            ascon_ctrl_pkg::INIT: begin
                op = last_round ? ascon_ctrl_pkg::OP_ROUND_KEYMIX : ascon_ctrl_pkg::OP_ROUND;
                if (last_round) state_nx = ascon_ctrl_pkg::WAIT_DATA;
            end
            ascon_ctrl_pkg::WAIT_DATA: if (accept) begin
                state_nx = ascon_ctrl_pkg::CT_OUT;
                if (i_last_block && !full_last) op = ascon_ctrl_pkg::OP_ABSORB_LAST;
                else                            op = ascon_ctrl_pkg::OP_ABSORB;
            end
            ascon_ctrl_pkg::CT_OUT: begin   // state holds while ciphertext is shown
                state_nx = (last_q && !full_q) ? ascon_ctrl_pkg::FINAL : ascon_ctrl_pkg::PB_ROUNDS;
            end
            ascon_ctrl_pkg::PB_ROUNDS: begin
                op = ascon_ctrl_pkg::OP_ROUND;
                if (last_round) begin
                    // full last block still owes the pad-only block
                    state_nx = last_q ? ascon_ctrl_pkg::EXTRA_PAD : ascon_ctrl_pkg::WAIT_DATA;
                end
            end
            ascon_ctrl_pkg::EXTRA_PAD: begin
                op       = ascon_ctrl_pkg::OP_ABSORB_EXTRA;
                state_nx = ascon_ctrl_pkg::FINAL;
            end
            ascon_ctrl_pkg::FINAL: begin
                op = ascon_ctrl_pkg::OP_ROUND;
                if (last_round) state_nx = ascon_ctrl_pkg::TAG_OUT;
            end
            ascon_ctrl_pkg::TAG_OUT: state_nx = ascon_ctrl_pkg::IDLE;
            default: state_nx = ascon_ctrl_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state       <= ascon_ctrl_pkg::IDLE;
            round_cnt   <= '0;
            last_q      <= 1'b0;
            full_q      <= 1'b0;
            ready_q     <= 1'b0;
            ct_pulse_q  <= 1'b0;
            tag_pulse_q <= 1'b0;
        end else begin
            state <= state_nx;
            if (state_nx != state) begin   // restart the count on every new phase
                round_cnt <= (state_nx == ascon_ctrl_pkg::PB_ROUNDS) ? PB_FIRST : '0;
            end else if (round_op) begin
                round_cnt <= round_cnt + 4'd1;
            end
            if (state == ascon_ctrl_pkg::WAIT_DATA && accept) begin
                last_q <= i_last_block;
                full_q <= full_last;
            end
            ready_q     <= (state_nx == ascon_ctrl_pkg::WAIT_DATA);
            ct_pulse_q  <= (state_nx == ascon_ctrl_pkg::CT_OUT);   // one cycle only
            tag_pulse_q <= (state_nx == ascon_ctrl_pkg::TAG_OUT);
        end
    end

    assign o_dp_op            = op;
    assign o_round_idx        = round_cnt;   // counter doubles as constant index
    assign o_ready_for_data   = ready_q;
    assign o_ciphertext_valid = ct_pulse_q;
    assign o_tag_valid        = tag_pulse_q;
    assign o_done             = tag_pulse_q; // done and tag always together

endmodule

/* verilog/ascon_ctrl_pkg.sv */
package ascon_ctrl_pkg;

    // sequencing states of the controller
    typedef enum logic [2:0] {
        IDLE, INIT, WAIT_DATA, CT_OUT, PB_ROUNDS, EXTRA_PAD, FINAL, TAG_OUT
    } ctrl_state_e;

    // what the datapath does to the state this cycle
    typedef enum logic [2:0] {
        OP_HOLD, OP_LOAD, OP_ROUND, OP_ROUND_KEYMIX,
        OP_ABSORB,        // xor block into rate, ciphertext out
        OP_ABSORB_LAST,   // padded partial block, then key into x2,x3
        OP_ABSORB_EXTRA   // pad-only block, then key into x2,x3
    } dp_op_e;

endpackage

/* verilog/ascon_data_pkg.sv */
`include "ascon_consts.svh"

package ascon_data_pkg;

    typedef logic [`ASCON_WORD_W-1:0]  word_t;   // one lane, or half of key/nonce
    typedef logic [`ASCON_BLOCK_W-1:0] block_t;  // data, ciphertext or tag block

    // x0 in the top word, x4 in the bottom one
    typedef logic [`ASCON_STATE_W-1:0] state_t;

    typedef logic [3:0] round_idx_t;  // round constant index 0..11

endpackage

/* verilog/ascon_datapath.sv */
`timescale 1ns/1ps
`include "ascon_consts.svh"

module ascon_datapath (
    input  logic                      clk,
    input  logic                      reset_n,
    input  ascon_ctrl_pkg::dp_op_e    i_dp_op,
    input  ascon_data_pkg::block_t    i_key,
    input  ascon_data_pkg::block_t    i_nonce,
    input  ascon_data_pkg::block_t    i_data,
    input  logic [`ASCON_BYTES_W-1:0] i_valid_bytes,
    input  ascon_data_pkg::state_t    i_round_state,   // next state from the round
    output ascon_data_pkg::state_t    o_state,
    output ascon_data_pkg::block_t    o_ciphertext,
    output ascon_data_pkg::block_t    o_tag
);

    ascon_data_pkg::state_t state_q, state_nx;
    ascon_data_pkg::block_t key_q;
    ascon_data_pkg::block_t ct_q;
    ascon_data_pkg::block_t data_pad;   // block as it enters the rate
    ascon_data_pkg::block_t rate_x;     // rate after absorb, also the ciphertext
    ascon_data_pkg::state_t absorbed;
    ascon_data_pkg::state_t key_mid;    // key lined up on x2,x3
    ascon_data_pkg::state_t key_tail;   // key lined up on x3,x4

    // padding, big-endian byte order, byte 0 in the top bits
    always_comb begin
        data_pad = i_data;
        if (i_dp_op == ascon_ctrl_pkg::OP_ABSORB_EXTRA) begin
            data_pad = {`ASCON_PAD_BYTE, {(`ASCON_BLOCK_W-8){1'b0}}};
        end else if (i_dp_op == ascon_ctrl_pkg::OP_ABSORB_LAST) begin
            data_pad = '0;
            for (int b = 0; b < `ASCON_BLOCK_W/8; b++) begin
                if (b < int'(i_valid_bytes)) begin
                    data_pad[`ASCON_BLOCK_W-1-8*b -: 8] = i_data[`ASCON_BLOCK_W-1-8*b -: 8];
                end else if (b == int'(i_valid_bytes)) begin
                    data_pad[`ASCON_BLOCK_W-1-8*b -: 8] = `ASCON_PAD_BYTE;
                end
            end
        end
    end

    assign rate_x   = state_q[`ASCON_STATE_W-1 -: `ASCON_BLOCK_W] ^ data_pad;   // x0||x1
    assign absorbed = {rate_x, state_q[`ASCON_STATE_W-`ASCON_BLOCK_W-1:0]};
    assign key_mid  = {{`ASCON_BLOCK_W{1'b0}}, key_q, {`ASCON_WORD_W{1'b0}}};
    assign key_tail = {{(`ASCON_STATE_W-`ASCON_BLOCK_W){1'b0}}, key_q};

    always_comb begin
        case (i_dp_op)
            ascon_ctrl_pkg::OP_LOAD:         state_nx = {`ASCON_IV, i_key, i_nonce};
            ascon_ctrl_pkg::OP_ROUND:        state_nx = i_round_state;
            // end of init, key into x3,x4 and domain bit for empty ad
            ascon_ctrl_pkg::OP_ROUND_KEYMIX: state_nx = i_round_state ^ key_tail
                                                        ^ `ASCON_STATE_W'(1);
            ascon_ctrl_pkg::OP_ABSORB:       state_nx = absorbed;
            ascon_ctrl_pkg::OP_ABSORB_LAST,
            ascon_ctrl_pkg::OP_ABSORB_EXTRA: state_nx = absorbed ^ key_mid;   // ahead of finalisation
            default:                         state_nx = state_q;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= '0;
            key_q   <= '0;
            ct_q    <= '0;
        end else begin
            state_q <= state_nx;
            if (i_dp_op == ascon_ctrl_pkg::OP_LOAD) begin
                key_q <= i_key;
            end
            // pad-only block gives no ciphertext
            if (i_dp_op == ascon_ctrl_pkg::OP_ABSORB || i_dp_op == ascon_ctrl_pkg::OP_ABSORB_LAST) begin
                ct_q <= rate_x;
            end
        end
    end

    assign o_state      = state_q;
    assign o_ciphertext = ct_q;   // stays until the next absorb
    assign o_tag        = state_q[`ASCON_BLOCK_W-1:0] ^ key_q;   // x3^k_hi || x4^k_lo

endmodule

/* verilog/ascon_round.sv */
`timescale 1ns/1ps
`include "ascon_consts.svh"

// one full ascon permutation round, purely combinational
module ascon_round (
    input  ascon_data_pkg::state_t     i_state,
    input  ascon_data_pkg::round_idx_t i_round_idx,
    output ascon_data_pkg::state_t     o_state
);

    // rotation amounts of the linear layer, per lane
    localparam int ROT_A [5] = '{19, 61, 1, 10, 7};
    localparam int ROT_B [5] = '{28, 39, 6, 17, 41};

    function automatic ascon_data_pkg::word_t rotr(input ascon_data_pkg::word_t x, input int n);
        return (x >> n) | (x << (`ASCON_WORD_W - n));
    endfunction

    ascon_data_pkg::word_t x [5];   // lanes after constant and s-box
    ascon_data_pkg::word_t t [5];   // chi terms
    logic [7:0]            rc;

    always_comb begin
        // round constant goes into the low byte of x2
        rc = {4'hF - i_round_idx, i_round_idx};
        for (int i = 0; i < 5; i++) begin
            x[i] = i_state[`ASCON_STATE_W-1-i*`ASCON_WORD_W -: `ASCON_WORD_W];
        end
        x[2] = x[2] ^ {{(`ASCON_WORD_W-8){1'b0}}, rc};

        // bitsliced 5-bit s-box, every column at once
        x[0] = x[0] ^ x[4];
        x[4] = x[4] ^ x[3];
        x[2] = x[2] ^ x[1];
        for (int i = 0; i < 5; i++) begin
            t[i] = ~x[i] & x[(i+1)%5];
        end
        for (int i = 0; i < 5; i++) begin
            x[i] = x[i] ^ t[(i+1)%5];
        end
        x[1] = x[1] ^ x[0];
        x[0] = x[0] ^ x[4];
        x[3] = x[3] ^ x[2];
        x[2] = ~x[2];
    end

    // linear diffusion, each lane with its own rotation pair
    for (genvar i = 0; i < 5; i++) begin : g_lin
        assign o_state[`ASCON_STATE_W-1-i*`ASCON_WORD_W -: `ASCON_WORD_W] =
            x[i] ^ rotr(x[i], ROT_A[i]) ^ rotr(x[i], ROT_B[i]);
    end

endmodule

/* verilog/ascon_top.sv */
`timescale 1ns/1ps
`include "ascon_consts.svh"

module ascon_top (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      i_start,
    input  ascon_data_pkg::block_t    i_key,
    input  ascon_data_pkg::block_t    i_nonce,
    input  ascon_data_pkg::block_t    i_data,
    input  logic                      i_valid_data,
    input  logic                      i_last_block,
    input  logic [`ASCON_BYTES_W-1:0] i_valid_bytes,
    output logic                      o_ready_for_data,
    output logic                      o_ciphertext_valid,
    output ascon_data_pkg::block_t    o_ciphertext,
    output logic                      o_tag_valid,
    output ascon_data_pkg::block_t    o_tag,
    output logic                      o_done
);

    ascon_ctrl_pkg::dp_op_e     dp_op;
    ascon_data_pkg::round_idx_t round_idx;
    ascon_data_pkg::state_t     cur_state;     // state register content
    ascon_data_pkg::state_t     round_state;   // one round applied

    ascon_ctrl ascon_ctrl_inst (
        .clk(clk), .reset_n(reset_n),
        .i_start(i_start), .i_valid_data(i_valid_data),
        .i_last_block(i_last_block), .i_valid_bytes(i_valid_bytes),
        .o_dp_op(dp_op), .o_round_idx(round_idx),
        .o_ready_for_data(o_ready_for_data), .o_ciphertext_valid(o_ciphertext_valid),
        .o_tag_valid(o_tag_valid), .o_done(o_done)
    );

    ascon_datapath ascon_datapath_inst (
        .clk(clk), .reset_n(reset_n),
        .i_dp_op(dp_op), .i_key(i_key), .i_nonce(i_nonce),
        .i_data(i_data), .i_valid_bytes(i_valid_bytes), .i_round_state(round_state),
        .o_state(cur_state), .o_ciphertext(o_ciphertext), .o_tag(o_tag)
    );

    ascon_round ascon_round_inst (
        .i_state(cur_state), .i_round_idx(round_idx), .o_state(round_state)
    );

endmodule
